// ==== sources.f ====
source/rf_pkg.sv
source/rf_bank.sv
source/rf_banked_array.sv
source/rf_read_issue.sv
source/rf_resp_queue.sv
source/rf_operand_fetch_top.sv
sim/rf_sva.sv
sim/rf_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the register file testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module rf_tb -f sources.f -o rf_sim

./obj_dir/rf_sim 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a pass status, see sim.log"
  exit 1
fi
echo "simulation passed"

// ==== sim/rf_tb.sv ====
/* rf_tb: random write and read traffic through the operand-fetch pipeline,
   checked against a register model with credit tracking */
`timescale 1ns/1ps

module rf_tb;
  import rf_pkg::*;

  localparam int          CLK_HALF       = 5;
  localparam int          RESET_CYCLES   = 16;
  localparam int          TIMEOUT_CYCLES = 500;
  localparam int          ADDR_W         = $bits(rf_addr_t);
  localparam int          BP_REQS        = RF_REQ_DEPTH + RF_RESP_DEPTH + RF_OUT_CREDITS;
  localparam logic [31:0] SEED           = 32'h88cf5c7b;

  logic                       clk_i;
  logic                       reset_i;
  rf_glob_wr_t                glob_wr_i;
  rf_bank_wr_t [RF_BANKS-1:0] bank_wr_i;
  logic                       req_valid_i;
  rf_rd_req_t                 req_i;
  logic                       req_credit_o;
  logic                       resp_credit_i;
  logic                       resp_valid_o;
  rf_rd_resp_t                resp_o;

  // reference register file and expected responses in send order
  rf_word_t            model [RF_ELS];
  rf_rd_resp_t         exp_q [$];
  rf_addr_t            recent [$];
  int                  sent_count = 0;
  int                  rd_idx = 0;
  int                  resp_count = 0;
  int                  credit_pulses = 0;
  int                  credits_returned = 0;
  logic                hold_credits;
  logic [RF_TAG_W-1:0] tag_next;

  rf_operand_fetch_top i_dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .glob_wr_i     (glob_wr_i),
    .bank_wr_i     (bank_wr_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_credit_o  (req_credit_o),
    .resp_credit_i (resp_credit_i),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_word(input string name, input rf_word_t got, input rf_word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_resp(input rf_rd_resp_t got, input rf_rd_resp_t exp);
    if (got.tag !== exp.tag) begin
      fail_run($sformatf("CHECK FAILED resp_o.tag: got 0x%h, expected 0x%h", got.tag, exp.tag));
    end
    // each operand on its own
    for (int j = 0; j < RF_NUM_RS; j++) begin
      check_word($sformatf("resp_o.data[%0d] tag 0x%h", j, exp.tag), got.data[j], exp.data[j]);
    end
  endtask

  function automatic rf_addr_t rand_addr();
    rf_addr_t a;
    a = ADDR_W'($urandom);
    return a;
  endfunction

  function automatic bit pipeline_idle();
    return (rd_idx == exp_q.size()) && (credits_returned == resp_count);
  endfunction

  task automatic drive_writes(input rf_glob_wr_t gw, input rf_bank_wr_t [RF_BANKS-1:0] bw);
    rf_addr_t a;
    @(posedge clk_i);
    glob_wr_i <= gw;
    bank_wr_i <= bw;
    // register 0 stays zero
    if (gw.valid && (gw.addr != '0)) begin
      model[gw.addr] = gw.data;
    end
    for (int b = 0; b < RF_BANKS; b++) begin
      a.bank = RF_BANK_W'(b);
      a.row  = bw[b].row;
      if (bw[b].valid && (a != '0)) begin
        model[a] = bw[b].data;
      end
    end
  endtask

  task automatic clear_writes();
    @(posedge clk_i);
    glob_wr_i <= '0;
    bank_wr_i <= '0;
  endtask

  task automatic send_req(input rf_addr_t a0, input rf_addr_t a1);
    rf_rd_req_t  req;
    rf_rd_resp_t exp;
    int          waited;
    waited = 0;
    @(posedge clk_i);
    while ((RF_REQ_DEPTH + credit_pulses - sent_count <= 0) && (waited < TIMEOUT_CYCLES)) begin
      req_valid_i <= 1'b0;
      waited++;
      @(posedge clk_i);
    end
    if (RF_REQ_DEPTH + credit_pulses - sent_count <= 0) begin
      fail_run("timed out waiting for a request credit from the DUT");
    end else begin
      req.tag     = tag_next;
      req.addr[0] = a0;
      req.addr[1] = a1;
      exp.tag     = tag_next;
      exp.data[0] = model[a0];
      exp.data[1] = model[a1];
      req_valid_i <= 1'b1;
      req_i       <= req;
      exp_q.push_back(exp);
      sent_count++;
      tag_next++;
    end
  endtask

  task automatic end_reqs();
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!pipeline_idle() && (waited < TIMEOUT_CYCLES)) begin
      waited++;
      @(negedge clk_i);
    end
    if (!pipeline_idle()) begin
      fail_run("timed out waiting for outstanding reads to drain");
    end
  endtask

  task automatic read_phase(input int n);
    rf_addr_t a0;
    rf_addr_t a1;
    for (int i = 0; i < n; i++) begin
      a0 = recent[$urandom_range(recent.size() - 1, 0)];
      if ($urandom_range(1, 0) == 1) begin
        // second operand in the same bank
        a1.bank = a0.bank;
        a1.row  = RF_ROW_W'($urandom);
      end else begin
        a1 = rand_addr();
      end
      send_req(a0, a1);
    end
    end_reqs();
    wait_idle();
  endtask

  task automatic global_write_phase(input int n);
    rf_glob_wr_t gw;
    recent.delete();
    for (int i = 0; i < n; i++) begin
      gw.valid = 1'b1;
      gw.addr  = rand_addr();
      gw.data  = $urandom;
      drive_writes(gw, '0);
      recent.push_back(gw.addr);
    end
    clear_writes();
  endtask

  // global write to one bank, bank port writes to the other three
  task automatic bank_write_cycle();
    rf_glob_wr_t                gw;
    rf_bank_wr_t [RF_BANKS-1:0] bw;
    rf_addr_t                   a;
    int                         g;
    g  = $urandom_range(RF_BANKS - 1, 0);
    gw = '0;
    bw = '0;
    recent.delete();
    for (int b = 0; b < RF_BANKS; b++) begin
      a.bank = RF_BANK_W'(b);
      a.row  = RF_ROW_W'($urandom);
      if (b == g) begin
        gw.valid = 1'b1;
        gw.addr  = a;
        gw.data  = $urandom;
      end else begin
        bw[b].valid = 1'b1;
        bw[b].row   = a.row;
        bw[b].data  = $urandom;
      end
      recent.push_back(a);
    end
    drive_writes(gw, bw);
    clear_writes();
  endtask

  initial begin : resp_monitor
    forever begin
      @(negedge clk_i);
      if (reset_i) begin
        if (req_credit_o) begin
          credit_pulses++;
        end
        if (resp_valid_o) begin
          if (rd_idx >= exp_q.size()) begin
            fail_run("response arrived with no request outstanding");
          end else begin
            check_resp(resp_o, exp_q[rd_idx]);
            rd_idx++;
            resp_count++;
          end
        end
      end
    end
  end

  // consumer hands back one credit per received response
  initial begin : credit_return
    resp_credit_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (!hold_credits && (resp_count > credits_returned)) begin
        resp_credit_i <= 1'b1;
        credits_returned++;
      end else begin
        resp_credit_i <= 1'b0;
      end
    end
  end

  initial begin : stimulus
    rf_glob_wr_t gw;
    int          base;
    void'($urandom(SEED));
    for (int i = 0; i < RF_ELS; i++) begin
      model[i] = '0;
    end
    reset_i      = 1'b0;
    glob_wr_i    = '0;
    bank_wr_i    = '0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    hold_credits = 1'b0;
    tag_next     = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b1;
    @(negedge clk_i);
    check_word("req_credit_o after reset", rf_word_t'(req_credit_o), '0);
    check_word("resp_valid_o after reset", rf_word_t'(resp_valid_o), '0);

    // every register gets a known value first
    for (int i = 0; i < RF_ELS; i++) begin
      gw.valid = 1'b1;
      gw.addr  = ADDR_W'(i);
      gw.data  = $urandom;
      drive_writes(gw, '0);
    end
    clear_writes();

    repeat (6) begin
      global_write_phase(8);
      read_phase(10);
    end

    repeat (4) begin
      bank_write_cycle();
      for (int i = 0; i < RF_BANKS; i++) begin
        send_req(recent[i], recent[(i + 1) % RF_BANKS]);
      end
      end_reqs();
      wait_idle();
      read_phase(6);
    end

    // register 0 ignores a non-zero write
    gw.valid = 1'b1;
    gw.addr  = '0;
    gw.data  = $urandom | 32'h1;
    drive_writes(gw, '0);
    clear_writes();
    send_req('0, '0);
    send_req('0, rand_addr());
    send_req(rand_addr(), '0);
    end_reqs();
    wait_idle();

    // consumer withholds credits, then releases them
    hold_credits = 1'b1;
    base = resp_count;
    for (int i = 0; i < BP_REQS; i++) begin
      send_req(rand_addr(), rand_addr());
    end
    end_reqs();
    repeat (40) @(negedge clk_i);
    check_word("responses without consumer credit", rf_word_t'(resp_count - base),
               rf_word_t'(RF_OUT_CREDITS));
    // full issue buffer holds back its upstream credits
    check_word("req_credit_o pulses withheld", rf_word_t'(sent_count - credit_pulses),
               rf_word_t'(RF_REQ_DEPTH));
    hold_credits = 1'b0;
    wait_idle();

    check_word("req_credit_o pulse count", rf_word_t'(credit_pulses), rf_word_t'(sent_count));
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== sim/rf_sva.sv ====
/* rf_sva: concurrent checks on write steering, array read timing and
   consumer credit flow */
`timescale 1ns/1ps

module rf_sva (
  input logic                                       clk_i,
  input logic                                       reset_i,
  input rf_pkg::rf_glob_wr_t                        glob_wr_i,
  input rf_pkg::rf_bank_wr_t [rf_pkg::RF_BANKS-1:0] bank_wr_i,
  input logic                                       fire_i,
  input logic                                       valid_i,
  input logic                                       resp_valid_i,
  input logic                                       resp_credit_i
);
  import rf_pkg::*;

  logic [RF_OUT_CNT_W-1:0] credit_q;

  // consumer credits as seen at the response port
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      credit_q <= RF_OUT_CNT_W'(RF_OUT_CREDITS);
    end else begin
      credit_q <= credit_q - RF_OUT_CNT_W'(resp_valid_i) + RF_OUT_CNT_W'(resp_credit_i);
    end
  end

  a_no_wr_collision: assert property (@(posedge clk_i) disable iff (!reset_i)
    glob_wr_i.valid |-> !bank_wr_i[glob_wr_i.addr.bank].valid)
    else $error("global write and bank write hit the same bank");

  a_fire_to_valid: assert property (@(posedge clk_i) disable iff (!reset_i)
    fire_i |=> valid_i)
    else $error("array valid missing one cycle after fire");

  a_valid_from_fire: assert property (@(posedge clk_i) disable iff (!reset_i)
    valid_i |-> $past(fire_i))
    else $error("array valid without a fire one cycle earlier");

  a_resp_has_credit: assert property (@(posedge clk_i) disable iff (!reset_i)
    resp_valid_i |-> (credit_q != '0))
    else $error("response sent while the consumer held no credit");

endmodule

bind rf_banked_array rf_sva i_sva_array (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .glob_wr_i     (glob_wr_i),
  .bank_wr_i     (bank_wr_i),
  .fire_i        (rd_fire_i),
  .valid_i       (rd_valid_o),
  .resp_valid_i  (1'b0),
  .resp_credit_i (1'b0)
);

bind rf_operand_fetch_top rf_sva i_sva_top (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .glob_wr_i     (glob_wr_i),
  .bank_wr_i     (bank_wr_i),
  .fire_i        (rd_fire),
  .valid_i       (arr_valid),
  .resp_valid_i  (resp_valid_o),
  .resp_credit_i (resp_credit_i)
);

// ==== source/rf_operand_fetch_top.sv ====
/* rf_operand_fetch_top: operand-fetch pipeline of request issue,
   banked register array and credited response queue */
`timescale 1ns/1ps

module rf_operand_fetch_top (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  rf_pkg::rf_glob_wr_t                        glob_wr_i,
  input  rf_pkg::rf_bank_wr_t [rf_pkg::RF_BANKS-1:0] bank_wr_i,
  input  logic                                       req_valid_i,
  input  rf_pkg::rf_rd_req_t                         req_i,
  output logic                                       req_credit_o,
  input  logic                                       resp_credit_i,
  output logic                                       resp_valid_o,
  output rf_pkg::rf_rd_resp_t                        resp_o
);
  import rf_pkg::*;

  logic        rd_fire;
  rf_rd_req_t  rd_req;
  logic        arr_valid;
  rf_rd_resp_t arr_resp;
  logic        slot_free;

  rf_read_issue u_issue (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_credit_o (req_credit_o),
    .slot_free_i  (slot_free),
    .rd_fire_o    (rd_fire),
    .rd_req_o     (rd_req)
  );

  rf_banked_array u_array (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .glob_wr_i  (glob_wr_i),
    .bank_wr_i  (bank_wr_i),
    .rd_fire_i  (rd_fire),
    .rd_req_i   (rd_req),
    .rd_valid_o (arr_valid),
    .rd_resp_o  (arr_resp)
  );

  rf_resp_queue u_queue (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .push_i        (arr_valid),
    .push_data_i   (arr_resp),
    .slot_free_o   (slot_free),
    .resp_credit_i (resp_credit_i),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o)
  );

endmodule

// ==== source/rf_resp_queue.sv ====
/* rf_resp_queue: four-entry response FIFO with a registered output,
   sending to the consumer under its credits and freeing issue credits */
`timescale 1ns/1ps

module rf_resp_queue (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                push_i,
  input  rf_pkg::rf_rd_resp_t push_data_i,
  output logic                slot_free_o,
  input  logic                resp_credit_i,
  output logic                resp_valid_o,
  output rf_pkg::rf_rd_resp_t resp_o
);
  import rf_pkg::*;

  rf_rd_resp_t               mem_q [RF_RESP_DEPTH];
  logic [RF_RESP_PTR_W-1:0]  wr_ptr_q;
  logic [RF_RESP_PTR_W-1:0]  rd_ptr_q;
  logic [RF_RESP_CNT_W-1:0]  count_q;
  logic [RF_OUT_CNT_W-1:0]   credit_q;
  logic                      pop;
  logic                      valid_q;
  rf_rd_resp_t               out_q;

  // head moves out whenever the consumer has room
  assign pop = (count_q != '0) && (credit_q != '0);

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= RF_OUT_CNT_W'(RF_OUT_CREDITS);
      valid_q  <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + RF_RESP_CNT_W'(push_i) - RF_RESP_CNT_W'(pop);
      credit_q <= credit_q - RF_OUT_CNT_W'(pop) + RF_OUT_CNT_W'(resp_credit_i);
      valid_q  <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // output register, loaded only on a pop
  always_ff @(posedge clk_i) begin
    if (pop) begin
      out_q <= mem_q[rd_ptr_q];
    end
  end

  assign slot_free_o  = pop;
  assign resp_valid_o = valid_q;
  assign resp_o       = out_q;

endmodule

// ==== source/rf_read_issue.sv ====
/* rf_read_issue: two-entry request buffer that fires reads into the array
   under response-queue credits and returns credits upstream */
`timescale 1ns/1ps

module rf_read_issue (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_valid_i,
  input  rf_pkg::rf_rd_req_t req_i,
  output logic               req_credit_o,
  input  logic               slot_free_i,
  output logic               rd_fire_o,
  output rf_pkg::rf_rd_req_t rd_req_o
);
  import rf_pkg::*;

  rf_rd_req_t               buf_q [RF_REQ_DEPTH];
  logic [RF_REQ_PTR_W-1:0]  wr_ptr_q;
  logic [RF_REQ_PTR_W-1:0]  rd_ptr_q;
  logic [RF_REQ_CNT_W-1:0]  count_q;
  logic [RF_REQ_CNT_W-1:0]  count_d;
  logic [RF_RESP_CNT_W-1:0] credit_q;
  logic [RF_RESP_CNT_W-1:0] credit_d;
  logic                     fire_q;
  logic                     fire_d;

  // next-cycle occupancy and credits decide the registered fire
  always_comb begin
    count_d  = count_q + RF_REQ_CNT_W'(req_valid_i) - RF_REQ_CNT_W'(fire_q);
    credit_d = credit_q - RF_RESP_CNT_W'(fire_q) + RF_RESP_CNT_W'(slot_free_i);
    fire_d   = (count_d != '0) && (credit_d != '0);
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= RF_RESP_CNT_W'(RF_RESP_DEPTH);
      fire_q   <= 1'b0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      // head is consumed in the cycle it fires
      if (fire_q) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q  <= count_d;
      credit_q <= credit_d;
      fire_q   <= fire_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      buf_q[wr_ptr_q] <= req_i;
    end
  end

  assign rd_req_o     = buf_q[rd_ptr_q];
  assign rd_fire_o    = fire_q;
  // one upstream credit per popped entry
  assign req_credit_o = fire_q;

endmodule

// ==== source/rf_banked_array.sv ====
/* rf_banked_array: four banks behind a global write port and per-bank
   write ports, reading two operands per request with a registered select */
`timescale 1ns/1ps

module rf_banked_array (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  rf_pkg::rf_glob_wr_t                          glob_wr_i,
  input  rf_pkg::rf_bank_wr_t [rf_pkg::RF_BANKS-1:0]   bank_wr_i,
  input  logic                                         rd_fire_i,
  input  rf_pkg::rf_rd_req_t                           rd_req_i,
  output logic                                         rd_valid_o,
  output rf_pkg::rf_rd_resp_t                          rd_resp_o
);
  import rf_pkg::*;

  logic [RF_BANKS-1:0]                  glob_bank_en;
  logic [RF_BANKS-1:0]                  bank_w_v;
  logic [RF_BANKS-1:0][RF_ROW_W-1:0]    bank_w_row;
  rf_word_t [RF_BANKS-1:0]              bank_w_data;
  logic [RF_BANKS-1:0][RF_NUM_RS-1:0]   bank_r_v;
  logic [RF_NUM_RS-1:0][RF_ROW_W-1:0]   r_row;
  rf_word_t [RF_BANKS-1:0][RF_NUM_RS-1:0] bank_r_data;

  logic [RF_NUM_RS-1:0][RF_BANK_W-1:0]  sel_q;
  logic [RF_TAG_W-1:0]                  tag_q;
  logic                                 valid_q;

  // global write bank decode
  always_comb begin
    for (int b = 0; b < RF_BANKS; b++) begin
      glob_bank_en[b] = glob_wr_i.valid && (glob_wr_i.addr.bank == RF_BANK_W'(b));
    end
  end

  // row part of each operand goes to every bank
  always_comb begin
    for (int j = 0; j < RF_NUM_RS; j++) begin
      r_row[j] = rd_req_i.addr[j].row;
    end
  end

  for (genvar b = 0; b < RF_BANKS; b++) begin : g_bank
    // one-hot pick between bank port and global port
    assign bank_w_v[b] = bank_wr_i[b].valid | glob_bank_en[b];
    assign bank_w_row[b] = ({RF_ROW_W{bank_wr_i[b].valid}} & bank_wr_i[b].row)
                         | ({RF_ROW_W{glob_bank_en[b]}} & glob_wr_i.addr.row);
    assign bank_w_data[b] = ({RF_WIDTH{bank_wr_i[b].valid}} & bank_wr_i[b].data)
                          | ({RF_WIDTH{glob_bank_en[b]}} & glob_wr_i.data);

    for (genvar j = 0; j < RF_NUM_RS; j++) begin : g_rv
      assign bank_r_v[b][j] = rd_fire_i && (rd_req_i.addr[j].bank == RF_BANK_W'(b));
    end

    rf_bank #(
      .zero_row_p((b == 0) ? 1 : 0)
    ) u_bank (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .w_v_i    (bank_w_v[b]),
      .w_row_i  (bank_w_row[b]),
      .w_data_i (bank_w_data[b]),
      .r_v_i    (bank_r_v[b]),
      .r_row_i  (r_row),
      .r_data_o (bank_r_data[b])
    );
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rd_fire_i;
    end
  end

  // bank select and tag follow the read by one cycle
  always_ff @(posedge clk_i) begin
    if (rd_fire_i) begin
      tag_q <= rd_req_i.tag;
      for (int j = 0; j < RF_NUM_RS; j++) begin
        sel_q[j] <= rd_req_i.addr[j].bank;
      end
    end
  end

  always_comb begin
    rd_resp_o.tag = tag_q;
    for (int j = 0; j < RF_NUM_RS; j++) begin
      rd_resp_o.data[j] = bank_r_data[sel_q[j]][j];
    end
  end

  assign rd_valid_o = valid_q;

endmodule

// ==== source/rf_bank.sv ====
/* rf_bank: one flop-based register bank with a single write port and
   synchronous read ports, row 0 optionally tied to zero */
`timescale 1ns/1ps

module rf_bank #(
  parameter int zero_row_p = 0
) (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic                                            w_v_i,
  input  logic [rf_pkg::RF_ROW_W-1:0]                     w_row_i,
  input  rf_pkg::rf_word_t                                w_data_i,
  input  logic [rf_pkg::RF_NUM_RS-1:0]                    r_v_i,
  input  logic [rf_pkg::RF_NUM_RS-1:0][rf_pkg::RF_ROW_W-1:0] r_row_i,
  output rf_pkg::rf_word_t [rf_pkg::RF_NUM_RS-1:0]        r_data_o
);
  import rf_pkg::*;

  rf_word_t mem_q [RF_ROWS];
  logic     w_en;
  logic [RF_NUM_RS-1:0] r_zero;

  // writes to a tied-off row 0 are dropped
  assign w_en = w_v_i && !((zero_row_p == 1) && (w_row_i == '0));

  always_comb begin
    for (int i = 0; i < RF_NUM_RS; i++) begin
      r_zero[i] = (zero_row_p == 1) && (r_row_i[i] == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_en) begin
      mem_q[w_row_i] <= w_data_i;
    end
  end

  // each read port holds its last word until read again
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      r_data_o <= '0;
    end else begin
      for (int i = 0; i < RF_NUM_RS; i++) begin
        if (r_v_i[i]) begin
          r_data_o[i] <= r_zero[i] ? '0 : mem_q[r_row_i[i]];
        end
      end
    end
  end

endmodule

// ==== source/rf_pkg.sv ====
/* rf_pkg: widths, counts, credit depths and packed structs shared by
   the banked operand-fetch register file */
package rf_pkg;

  // array geometry
  localparam int RF_WIDTH  = 32;
  localparam int RF_BANKS  = 4;
  localparam int RF_ROWS   = 16;
  localparam int RF_ELS    = RF_BANKS * RF_ROWS;
  localparam int RF_NUM_RS = 2;
  localparam int RF_BANK_W = 2;
  localparam int RF_ROW_W  = 4;
  localparam int RF_TAG_W  = 4;

  // buffer depths, each also a starting credit count
  localparam int RF_REQ_DEPTH   = 2;
  localparam int RF_RESP_DEPTH  = 4;
  localparam int RF_OUT_CREDITS = 4;

  // counter and pointer widths
  localparam int RF_REQ_CNT_W  = $clog2(RF_REQ_DEPTH + 1);
  localparam int RF_REQ_PTR_W  = $clog2(RF_REQ_DEPTH);
  localparam int RF_RESP_CNT_W = $clog2(RF_RESP_DEPTH + 1);
  localparam int RF_RESP_PTR_W = $clog2(RF_RESP_DEPTH);
  localparam int RF_OUT_CNT_W  = $clog2(RF_OUT_CREDITS + 1);

  typedef logic [RF_WIDTH-1:0] rf_word_t;

  // bank in the high bits, row in the low bits
  typedef struct packed {
    logic [RF_BANK_W-1:0] bank;
    logic [RF_ROW_W-1:0]  row;
  } rf_addr_t;

  typedef struct packed {
    logic     valid;
    rf_addr_t addr;
    rf_word_t data;
  } rf_glob_wr_t;

  typedef struct packed {
    logic                valid;
    logic [RF_ROW_W-1:0] row;
    rf_word_t            data;
  } rf_bank_wr_t;

  typedef struct packed {
    logic [RF_TAG_W-1:0]           tag;
    rf_addr_t [RF_NUM_RS-1:0]      addr;
  } rf_rd_req_t;

  typedef struct packed {
    logic [RF_TAG_W-1:0]           tag;
    rf_word_t [RF_NUM_RS-1:0]      data;
  } rf_rd_resp_t;

endpackage
